// File: Bender.yml
package:
  name: striped_fifo

dependencies: {}

sources:
  # Design, in compile order
  - rtl/stripe_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/axis_lane_fifo.sv
  - rtl/lane_spreader.sv
  - rtl/lane_gatherer.sv
  - rtl/striped_fifo_top.sv

  # Testbench
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/striped_fifo_tb.sv

export_include_dirs: []

# Testbench top: striped_fifo_tb, design top: striped_fifo_top

// File: rtl/axis_lane_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axis_lane_fifo #(
   parameter int DATA_WIDTH       = 16,
   parameter int DEPTH            = 8,
   parameter int PROG_FULL_THRESH = 0
) (
   input  logic                  out,
   input  logic                  rst_n,
   input  logic                  up_valid,
   output logic                  up_ready,
   input  logic [DATA_WIDTH-1:0] up_data,
   output logic                  dn_valid,
   input  logic                  dn_ready,
   output logic [DATA_WIDTH-1:0] dn_data
);

   logic we;
   logic re;
   logic empty;
   logic almost_full;
   logic prog_full;

   ////////////////////////////////////////////////////////////
   // Handshake to memory enables
   ////////////////////////////////////////////////////////////

   assign we = up_valid & up_ready;

   // Pop when the output stage is free or emptying this cycle
   assign re = ~empty & (dn_ready | ~dn_valid);

   // Threshold of zero falls back to almost-full
   assign up_ready = (PROG_FULL_THRESH != 0) ? ~prog_full : ~almost_full;

   // Output valid stage, dout of the memory is the payload
   always_ff @(posedge out) begin
      if (!rst_n) begin
         dn_valid <= 1'b0;
      end else if (re) begin
         dn_valid <= 1'b1;
      end else if (dn_ready) begin
         dn_valid <= 1'b0;
      end
   end

   sync_fifo #(
      .DATA_WIDTH       (DATA_WIDTH),
      .DEPTH            (DEPTH),
      .PROG_FULL_THRESH (PROG_FULL_THRESH)
   ) fifo_i (
      .out         (out),
      .rst_n       (rst_n),
      .we          (we),
      .din         (up_data),
      .re          (re),
      .empty       (empty),
      .dout        (dn_data),
      .almost_full (almost_full),
      .prog_full   (prog_full)
   );

   // A stalled beat stays put until taken
   assert property (@(posedge out) disable iff (!rst_n)
      (dn_valid && !dn_ready) |=> (dn_valid && $stable(dn_data)))
      else $error("axis_lane_fifo output changed under back-pressure");

endmodule

`default_nettype wire

// File: rtl/lane_gatherer.sv
`timescale 1ns/1ps
`default_nettype none

module lane_gatherer
   import stripe_pkg::*;
#(
   parameter int DATA_WIDTH = DEF_DATA_WIDTH,
   parameter int LANES      = DEF_LANES
) (
   input  logic                                out,
   input  logic                                rst_n,
   input  logic [LANES-1:0]                    lane_valid,
   output logic [LANES-1:0]                    lane_ready,
   input  logic [LANES-1:0][DATA_WIDTH-1:0]    lane_data,
   output logic                                dn_valid,
   input  logic                                dn_ready,
   output logic [DATA_WIDTH-1:0]               dn_data
);

   localparam int PW = lane_idx_w(LANES);

   logic [PW-1:0]    rd_ptr;
   logic [LANES-1:0] lane_sel;
   logic             take;

   ////////////////////////////////////////////////////////////
   // Output mux
   ////////////////////////////////////////////////////////////

   // Same walk as the spreader keeps the order
   assign lane_sel = LANES'(1) << rd_ptr;

   assign dn_valid = lane_valid[rd_ptr];
   assign dn_data  = lane_data[rd_ptr];

   // Other lanes stay stalled until their turn
   assign lane_ready = dn_ready ? lane_sel : '0;

   assign take = dn_valid & dn_ready;

   always_ff @(posedge out) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (take) begin
         rd_ptr <= rd_ptr + PW'(1);
      end
   end

endmodule

`default_nettype wire

// File: rtl/lane_spreader.sv
`timescale 1ns/1ps
`default_nettype none

module lane_spreader
   import stripe_pkg::*;
#(
   parameter int DATA_WIDTH = DEF_DATA_WIDTH,
   parameter int LANES      = DEF_LANES
) (
   input  logic                  out,
   input  logic                  rst_n,
   input  logic                  up_valid,
   output logic                  up_ready,
   input  logic [DATA_WIDTH-1:0] up_data,
   output logic [LANES-1:0]      lane_valid,
   input  logic [LANES-1:0]      lane_ready,
   output logic [DATA_WIDTH-1:0] lane_data
);

   localparam int PW = lane_idx_w(LANES);

   logic [PW-1:0]    wr_ptr;
   logic [LANES-1:0] lane_sel;
   logic             accept;

   ////////////////////////////////////////////////////////////
   // Lane select
   ////////////////////////////////////////////////////////////

   assign lane_sel = LANES'(1) << wr_ptr;

   // Ready comes only from the lane next in turn
   assign up_ready = lane_ready[wr_ptr];
   assign accept   = up_valid & up_ready;

   assign lane_valid = up_valid ? lane_sel : '0;

   // Data is broadcast, the valid bit picks the lane
   assign lane_data = up_data;

   // Write pointer, wraps with the power-of-two lane count
   always_ff @(posedge out) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (accept) begin
         wr_ptr <= wr_ptr + PW'(1);
      end
   end

   // At most one lane sees a write per cycle
   assert property (@(posedge out) disable iff (!rst_n)
      $onehot0(lane_valid))
      else $error("lane_spreader lane_valid not one-hot");

endmodule

`default_nettype wire

// File: rtl/stripe_pkg.sv
`default_nettype none

package stripe_pkg;

   ////////////////////////////////////////////////////////////
   // Default configuration of the striped buffer
   ////////////////////////////////////////////////////////////

   // Beat width
   localparam int DEF_DATA_WIDTH = 16;

   // Lane count, power of two, at least 2
   localparam int DEF_LANES = 4;

   // Entries per lane memory, power of two
   localparam int DEF_DEPTH = 8;

   // Zero selects the almost-full ready policy
   localparam int DEF_PROG_FULL_THRESH = 0;

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // Round-robin pointer width for a given lane count
   function automatic int lane_idx_w(input int lanes);
      int w;
      w = (lanes > 1) ? $clog2(lanes) : 1;
      return w;
   endfunction

endpackage

`default_nettype wire

// File: rtl/striped_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module striped_fifo_top
   import stripe_pkg::*;
#(
   parameter int DATA_WIDTH       = DEF_DATA_WIDTH,
   parameter int LANES            = DEF_LANES,
   parameter int DEPTH            = DEF_DEPTH,
   parameter int PROG_FULL_THRESH = DEF_PROG_FULL_THRESH
) (
   input  logic                  out,
   input  logic                  rst_n,
   input  logic                  up_valid,
   output logic                  up_ready,
   input  logic [DATA_WIDTH-1:0] up_data,
   output logic                  dn_valid,
   input  logic                  dn_ready,
   output logic [DATA_WIDTH-1:0] dn_data
);

   if (LANES < 2 || (1 << lane_idx_w(LANES)) != LANES) begin : g_bad_lanes
      $error("striped_fifo_top LANES must be a power of two of at least 2");
   end

   // Spreader side
   logic [LANES-1:0]      lane_valid;
   logic [LANES-1:0]      lane_ready;
   logic [DATA_WIDTH-1:0] lane_data;

   // Gatherer side
   logic [LANES-1:0]                 out_valid;
   logic [LANES-1:0]                 out_ready;
   logic [LANES-1:0][DATA_WIDTH-1:0] out_data;

   lane_spreader #(
      .DATA_WIDTH (DATA_WIDTH),
      .LANES      (LANES)
   ) spreader_i (
      .out        (out),
      .rst_n      (rst_n),
      .up_valid   (up_valid),
      .up_ready   (up_ready),
      .up_data    (up_data),
      .lane_valid (lane_valid),
      .lane_ready (lane_ready),
      .lane_data  (lane_data)
   );

   ////////////////////////////////////////////////////////////
   // Lane FIFOs
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < LANES; i++) begin : g_lane
      axis_lane_fifo #(
         .DATA_WIDTH       (DATA_WIDTH),
         .DEPTH            (DEPTH),
         .PROG_FULL_THRESH (PROG_FULL_THRESH)
      ) lane_i (
         .out      (out),
         .rst_n    (rst_n),
         .up_valid (lane_valid[i]),
         .up_ready (lane_ready[i]),
         .up_data  (lane_data),
         .dn_valid (out_valid[i]),
         .dn_ready (out_ready[i]),
         .dn_data  (out_data[i])
      );
   end

   lane_gatherer #(
      .DATA_WIDTH (DATA_WIDTH),
      .LANES      (LANES)
   ) gatherer_i (
      .out        (out),
      .rst_n      (rst_n),
      .lane_valid (out_valid),
      .lane_ready (out_ready),
      .lane_data  (out_data),
      .dn_valid   (dn_valid),
      .dn_ready   (dn_ready),
      .dn_data    (dn_data)
   );

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int DATA_WIDTH       = 16,
   parameter int DEPTH            = 8,
   parameter int PROG_FULL_THRESH = 0
) (
   input  logic                  out,
   input  logic                  rst_n,
   input  logic                  we,
   input  logic [DATA_WIDTH-1:0] din,
   input  logic                  re,
   output logic                  empty,
   output logic [DATA_WIDTH-1:0] dout,
   output logic                  almost_full,
   output logic                  prog_full
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   // Flag levels at count width
   localparam logic [CW-1:0] AF_LEVEL = CW'(DEPTH - 1);
   localparam logic [CW-1:0] PF_LEVEL = CW'(PROG_FULL_THRESH);
   localparam logic [CW-1:0] FULL_LEVEL = CW'(DEPTH);

   if (DEPTH < 2 || (1 << AW) != DEPTH) begin : g_bad_depth
      $error("sync_fifo DEPTH must be a power of two of at least 2");
   end

   if (PROG_FULL_THRESH < 0 || PROG_FULL_THRESH > DEPTH) begin : g_bad_thresh
      $error("sync_fifo PROG_FULL_THRESH out of range");
   end

   logic [DATA_WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [CW-1:0]         count;

   ////////////////////////////////////////////////////////////
   // Storage and registered read port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge out) begin
      if (we) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge out) begin
      if (re) begin
         dout <= mem[rd_ptr];
      end
   end

   ////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////

   // Pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge out) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (we) begin
            wr_ptr <= wr_ptr + AW'(1);
         end
         if (re) begin
            rd_ptr <= rd_ptr + AW'(1);
         end
         case ({we, re})
            2'b10:   count <= count + CW'(1);
            2'b01:   count <= count - CW'(1);
            default: count <= count;
         endcase
      end
   end

   assign empty       = (count == '0);
   assign almost_full = (count >= AF_LEVEL);
   assign prog_full   = (count >= PF_LEVEL);

   // Upstream ready policy must keep writes off a full memory
   assert property (@(posedge out) disable iff (!rst_n)
      !(we && count == FULL_LEVEL))
      else $error("sync_fifo write while full");

   // Read side must never pop an empty memory
   assert property (@(posedge out) disable iff (!rst_n)
      !(re && empty))
      else $error("sync_fifo read while empty");

endmodule

`default_nettype wire

// File: tb.f
rtl/stripe_pkg.sv
rtl/sync_fifo.sv
rtl/axis_lane_fifo.sv
rtl/lane_spreader.sv
rtl/lane_gatherer.sv
rtl/striped_fifo_top.sv
tb/tb_clock_gen.sv
tb/striped_fifo_tb.sv

// File: tb/striped_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module striped_fifo_tb;

   localparam int DATA_WIDTH  = 16;
   localparam int LANES       = 4;
   localparam int DEPTH       = 8;
   localparam int CAPACITY    = LANES * DEPTH;
   localparam int MAX_CYCLES  = 12000;
   localparam int DRAIN_LIMIT = 4 * CAPACITY;

   logic                  out;
   logic                  por_n;
   logic                  soft_rst_n;
   logic                  rst_n;
   logic                  up_valid;
   logic                  up_ready;
   logic [DATA_WIDTH-1:0] up_data;
   logic                  dn_valid;
   logic                  dn_ready;
   logic [DATA_WIDTH-1:0] dn_data;

   // Scoreboard and its registered mirror for the assertions
   logic [DATA_WIDTH-1:0] sb_q [$];
   logic [DATA_WIDTH-1:0] sb_head;
   int                    sb_size;
   logic [DATA_WIDTH-1:0] held_data;
   logic                  acc_q;
   int                    in_count;
   int                    out_count;
   int                    cycle_count;
   logic                  full_check;
   logic                  drain_check;
   logic [DATA_WIDTH-1:0] seq_val;

   assign rst_n = por_n & soft_rst_n;

   tb_clock_gen #(
      .PERIOD_NS    (100),
      .RESET_CYCLES (2)
   ) clock_gen_i (
      .out   (out),
      .rst_n (por_n)
   );

   striped_fifo_top #(
      .DATA_WIDTH       (DATA_WIDTH),
      .LANES            (LANES),
      .DEPTH            (DEPTH),
      .PROG_FULL_THRESH (0)
   ) dut_i (
      .out      (out),
      .rst_n    (rst_n),
      .up_valid (up_valid),
      .up_ready (up_ready),
      .up_data  (up_data),
      .dn_valid (dn_valid),
      .dn_ready (dn_ready),
      .dn_data  (dn_data)
   );

   ////////////////////////////////////////////////////////////
   // Failure reporting
   ////////////////////////////////////////////////////////////

   task automatic stop_run();
      $display(">>> FAIL");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Error at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
      stop_run();
   endtask

   task automatic report_problem(input string what);
      $display("Failure at %0d ns: %s", $time, what);
      stop_run();
   endtask

   ////////////////////////////////////////////////////////////
   // Monitor and scoreboard
   ////////////////////////////////////////////////////////////

   // Pop before push since a beat never leaves in the cycle it enters
   always @(posedge out) begin
      if (!rst_n) begin
         sb_q.delete();
         in_count  <= 0;
         out_count <= 0;
         acc_q     <= 1'b0;
      end else begin
         if (dn_valid && dn_ready && sb_q.size() != 0) begin
            void'(sb_q.pop_front());
         end
         if (up_valid && up_ready) begin
            sb_q.push_back(up_data);
         end
         acc_q     <= up_valid && up_ready;
         in_count  <= in_count + int'(up_valid && up_ready);
         out_count <= out_count + int'(dn_valid && dn_ready);
      end
      sb_head   <= (sb_q.size() != 0) ? sb_q[0] : '0;
      sb_size   <= sb_q.size();
      held_data <= dn_data;
   end

   always @(posedge out) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         report_problem($sformatf("Timeout, the run did not finish in %0d cycles", MAX_CYCLES));
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   a_order: assert property (@(posedge out) disable iff (!rst_n)
      (dn_valid && dn_ready && sb_size != 0) |-> (dn_data == sb_head))
      else report_mismatch("dn_data", $sampled(sb_head), $sampled(dn_data));

   a_no_extra: assert property (@(posedge out) disable iff (!rst_n)
      (dn_valid && dn_ready) |-> (sb_size != 0))
      else report_problem("An output beat appeared with no input beat waiting for it");

   a_capacity: assert property (@(posedge out) disable iff (!rst_n)
      sb_size <= CAPACITY)
      else report_problem("The buffer accepted more beats than it can hold");

   a_full_ready: assert property (@(posedge out) disable iff (!rst_n)
      full_check |-> !up_ready)
      else report_mismatch("up_ready", 0, $sampled(up_ready));

   a_full_count: assert property (@(posedge out) disable iff (!rst_n)
      full_check |-> (sb_size == CAPACITY))
      else report_mismatch("accepted beats", CAPACITY, $sampled(sb_size));

   // Held beat under back-pressure
   a_hold_valid: assert property (@(posedge out) disable iff (!rst_n)
      (dn_valid && !dn_ready) |=> dn_valid)
      else report_mismatch("dn_valid", 1, $sampled(dn_valid));

   a_hold_data: assert property (@(posedge out) disable iff (!rst_n)
      (dn_valid && !dn_ready) |=> $stable(dn_data))
      else report_mismatch("dn_data", $sampled(held_data), $sampled(dn_data));

   a_reset_valid: assert property (@(posedge out) $rose(rst_n) |-> !dn_valid)
      else report_mismatch("dn_valid", 0, $sampled(dn_valid));

   a_reset_ready: assert property (@(posedge out) $rose(rst_n) |-> up_ready)
      else report_mismatch("up_ready", 1, $sampled(up_ready));

   a_drained: assert property (@(posedge out) disable iff (!rst_n)
      drain_check |-> (sb_size == 0))
      else report_mismatch("scoreboard size", 0, $sampled(sb_size));

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   function automatic logic coin(input int pct);
      return ($urandom % 100) < pct;
   endfunction

   // Every task starts and ends 10 ns after a rising edge
   task automatic send_stream(input int n, input bit rand_data, input bit throttle,
                              input bit drain);
      int pushed;
      int target;
      pushed = 0;
      target = out_count + n;
      while (pushed < n || (drain && out_count < target)) begin
         if (acc_q) begin
            pushed++;
         end
         if (pushed >= n) begin
            up_valid = 1'b0;
         end else if (!(up_valid && !acc_q)) begin
            up_valid = throttle ? coin(60) : 1'b1;
            if (up_valid) begin
               up_data = rand_data ? DATA_WIDTH'($urandom) : seq_val;
               seq_val = seq_val + 1'b1;
            end
         end
         dn_ready = throttle ? coin(60) : 1'b1;
         @(posedge out);
         #10;
      end
      up_valid = 1'b0;
   endtask

   task automatic fill_until_blocked(input int cycles);
      dn_ready = 1'b0;
      repeat (cycles) begin
         if (!(up_valid && !acc_q)) begin
            up_data = seq_val;
            seq_val = seq_val + 1'b1;
         end
         up_valid = 1'b1;
         @(posedge out);
         #10;
      end
      // Still offering a beat while the full state is checked
      full_check = 1'b1;
      @(posedge out);
      #10;
      full_check = 1'b0;
      up_valid   = 1'b0;
   endtask

   task automatic drain_buffer();
      int waited;
      waited   = 0;
      up_valid = 1'b0;
      dn_ready = 1'b1;
      // Bounded wait for the last beats to leave
      while (out_count < in_count && waited < DRAIN_LIMIT) begin
         @(posedge out);
         #10;
         waited++;
      end
      drain_check = 1'b1;
      @(posedge out);
      #10;
      drain_check = 1'b0;
   endtask

   task automatic pulse_reset();
      up_valid   = 1'b0;
      dn_ready   = 1'b0;
      soft_rst_n = 1'b0;
      repeat (2) begin
         @(posedge out);
         #10;
      end
      soft_rst_n = 1'b1;
   endtask

   initial begin
      void'($urandom(15750));
      soft_rst_n  = 1'b1;
      up_valid    = 1'b0;
      up_data     = '0;
      dn_ready    = 1'b0;
      full_check  = 1'b0;
      drain_check = 1'b0;
      seq_val     = '0;
      cycle_count = 0;
      wait (por_n === 1'b1);
      @(posedge out);
      #10;
      send_stream(500, 1'b0, 1'b0, 1'b1);
      drain_buffer();
      fill_until_blocked(CAPACITY + 50);
      drain_buffer();
      send_stream(1500, 1'b1, 1'b1, 1'b1);
      drain_buffer();
      // Leave beats inside with the write pointer past lane 0
      send_stream(23, 1'b0, 1'b1, 1'b0);
      pulse_reset();
      send_stream(200, 1'b0, 1'b1, 1'b1);
      drain_buffer();
      if (in_count != out_count || sb_size != 0) begin
         report_problem("Beats were left in the buffer at the end of the run");
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 2
) (
   output logic out,
   output logic rst_n
);

   initial begin
      out = 1'b0;
      forever #(PERIOD_NS / 2) out = ~out;
   end

   // Release lands just after an edge, like the other inputs
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge out);
      #10 rst_n = 1'b1;
   end

endmodule

`default_nettype wire
